// ==== files.f ====
+incdir+logic
+incdir+verif
logic/ialu_cmd_pkg.sv
logic/ialu_data_pkg.sv
logic/ialu_decode.sv
logic/ialu_execute.sv
logic/ialu_result.sv
logic/ialu_top.sv
verif/ialu_tb.sv

// ==== logic/ialu_cmd_pkg.sv ====
/* Command encoding of the ALU and the decoded-operation types that the decode
   stage produces. Imported by the RTL stages and by the data package. */

`include "ialu_defines.svh"

package ialu_cmd_pkg;

    //--------------------------------------------------
    // External command
    //--------------------------------------------------
    typedef enum logic [`IALU_CMD_W-1:0] {
        ialu_cmd_none    = 4'd0,    // No operation, no rdy
        ialu_cmd_and     = 4'd1,
        ialu_cmd_or      = 4'd2,
        ialu_cmd_xor     = 4'd3,
        ialu_cmd_add     = 4'd4,
        ialu_cmd_sub     = 4'd5,
        ialu_cmd_sub_lt  = 4'd6,    // Signed less-than
        ialu_cmd_sub_ltu = 4'd7,    // Unsigned less-than
        ialu_cmd_sub_eq  = 4'd8,
        ialu_cmd_sub_ne  = 4'd9,
        ialu_cmd_sub_ge  = 4'd10,   // Signed greater-or-equal
        ialu_cmd_sub_geu = 4'd11,   // Unsigned greater-or-equal
        ialu_cmd_sll     = 4'd12,
        ialu_cmd_srl     = 4'd13,
        ialu_cmd_sra     = 4'd14
    } ialu_cmd_e;

    //--------------------------------------------------
    // Decoded operation
    //--------------------------------------------------
    // Unit that supplies the final result
    typedef enum logic [2:0] {
        ialu_class_none,
        ialu_class_logic,
        ialu_class_sum,
        ialu_class_cmp,
        ialu_class_shift
    } ialu_class_e;

    typedef enum logic [1:0] {ialu_logic_and, ialu_logic_or, ialu_logic_xor} ialu_logic_e;

    typedef enum logic [1:0] {ialu_shift_sll, ialu_shift_srl, ialu_shift_sra} ialu_shift_e;

    typedef enum logic [2:0] {
        ialu_cmp_lt, ialu_cmp_ltu, ialu_cmp_eq, ialu_cmp_ne, ialu_cmp_ge, ialu_cmp_geu
    } ialu_cmp_e;

    typedef struct packed {
        ialu_class_e op_class;      // Result source
        logic        sub;           // Main adder subtracts
        ialu_logic_e logic_op;
        ialu_shift_e shift_op;
        ialu_cmp_e   cmp_op;
    } ialu_dec_s;

endpackage

// ==== logic/ialu_data_pkg.sv ====
/* Data word, adder flags and the structs that carry a command between the
   ALU stages and across the top-level ports. */

`include "ialu_defines.svh"

package ialu_data_pkg;

    import ialu_cmd_pkg::*;

    typedef logic [`IALU_XLEN-1:0] ialu_word_t;

    // Main adder status, taken from the 33-bit sum
    typedef struct packed {
        logic zero;     // Low word all zero
        logic sign;     // Bit 31 of the sum
        logic ovfl;     // Signed overflow
        logic carry;    // Bit 32, borrow on subtract
    } ialu_flags_s;

    //--------------------------------------------------
    // Stage structs
    //--------------------------------------------------
    typedef struct packed {
        logic       valid;      // Plain strobe, no handshake
        ialu_cmd_e  cmd;
        ialu_word_t op1;
        ialu_word_t op2;
    } ialu_req_s;

    // Registered request after decode
    typedef struct packed {
        logic       valid;
        ialu_dec_s  dec;
        ialu_word_t op1;
        ialu_word_t op2;
    } ialu_stage_s;

    // All unit outputs, the result stage picks one
    typedef struct packed {
        logic        valid;
        ialu_class_e op_class;
        ialu_cmp_e   cmp_op;
        ialu_word_t  sum;           // Wrapped sum or difference
        ialu_flags_s flags;
        ialu_word_t  shift_res;
        ialu_word_t  logic_res;
    } ialu_exec_s;

    typedef struct packed {
        logic       rdy;        // One-cycle result pulse
        logic       cmp;        // Compare outcome
        ialu_word_t res;
    } ialu_rsp_s;

endpackage

// ==== logic/ialu_decode.sv ====
/* Input register stage of the ALU. Decodes the external command into unit
   controls and registers them with the operands, one cycle of latency. */

`timescale 1ns/100ps

module ialu_decode (
    input  logic                       clk,
    input  logic                       rst_n,
    input  ialu_data_pkg::ialu_req_s   req_i,      // Request from issue
    output ialu_data_pkg::ialu_stage_s stage_o     // Registered decoded request
);

    import ialu_cmd_pkg::*;
    import ialu_data_pkg::*;

    // Idle decode, also the reset value of the stage
    localparam ialu_dec_s dec_none = '{
        op_class: ialu_class_none,
        sub:      1'b0,
        logic_op: ialu_logic_and,
        shift_op: ialu_shift_sll,
        cmp_op:   ialu_cmp_lt
    };

    ialu_dec_s  dec_d;          // Decode of the incoming command
    logic       valid_q;
    ialu_dec_s  dec_q;
    ialu_word_t op1_q;
    ialu_word_t op2_q;

    //--------------------------------------------------
    // Command decode
    //--------------------------------------------------
    always_comb begin
        dec_d = dec_none;
        case (req_i.cmd)
            ialu_cmd_and: begin
                dec_d.op_class = ialu_class_logic;
                dec_d.logic_op = ialu_logic_and;
            end
            ialu_cmd_or: begin
                dec_d.op_class = ialu_class_logic;
                dec_d.logic_op = ialu_logic_or;
            end
            ialu_cmd_xor: begin
                dec_d.op_class = ialu_class_logic;
                dec_d.logic_op = ialu_logic_xor;
            end
            ialu_cmd_add: dec_d.op_class = ialu_class_sum;
            ialu_cmd_sub: begin
                dec_d.op_class = ialu_class_sum;
                dec_d.sub      = 1'b1;
            end
            ialu_cmd_sub_lt,
            ialu_cmd_sub_ltu,
            ialu_cmd_sub_eq,
            ialu_cmd_sub_ne,
            ialu_cmd_sub_ge,
            ialu_cmd_sub_geu: begin
                dec_d.op_class = ialu_class_cmp;
                dec_d.sub      = 1'b1;          // Compares resolve from op1 - op2
                case (req_i.cmd)
                    ialu_cmd_sub_lt:  dec_d.cmp_op = ialu_cmp_lt;
                    ialu_cmd_sub_ltu: dec_d.cmp_op = ialu_cmp_ltu;
                    ialu_cmd_sub_eq:  dec_d.cmp_op = ialu_cmp_eq;
                    ialu_cmd_sub_ne:  dec_d.cmp_op = ialu_cmp_ne;
                    ialu_cmd_sub_ge:  dec_d.cmp_op = ialu_cmp_ge;
                    default:          dec_d.cmp_op = ialu_cmp_geu;
                endcase
            end
            ialu_cmd_sll: dec_d.op_class = ialu_class_shift;    // Default kind is sll
            ialu_cmd_srl: begin
                dec_d.op_class = ialu_class_shift;
                dec_d.shift_op = ialu_shift_srl;
            end
            ialu_cmd_sra: begin
                dec_d.op_class = ialu_class_shift;
                dec_d.shift_op = ialu_shift_sra;
            end
            default: dec_d = dec_none;      // NONE and unused codes
        endcase
    end

    //--------------------------------------------------
    // Input register
    //--------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            dec_q   <= dec_none;
        end else begin
            valid_q <= req_i.valid;
            dec_q   <= dec_d;
        end
    end

    // Operands follow the command every cycle
    always_ff @(posedge clk) begin
        op1_q <= req_i.op1;
        op2_q <= req_i.op2;
    end

    assign stage_o = '{valid: valid_q, dec: dec_q, op1: op1_q, op2: op2_q};

endmodule

// ==== logic/ialu_defines.svh ====
/* Width macros for the integer ALU.
   Included by both packages and by every module that sizes vectors on its own. */

`ifndef IALU_DEFINES_SVH
`define IALU_DEFINES_SVH

// Data path
`define IALU_XLEN     32    // Data word width
`define IALU_SHAMT_W  5     // Low op2 bits taken as shift amount

// Command interface
`define IALU_CMD_W    4     // External command code width

// Derived decode field widths live with the types in ialu_cmd_pkg

`endif

// ==== logic/ialu_execute.sv ====
/* Combinational execute stage of the ALU: main adder with flags, shifter,
   logic unit and the separate address adder. All units run every cycle. */

`timescale 1ns/100ps

`include "ialu_defines.svh"

module ialu_execute (
    input  ialu_data_pkg::ialu_stage_s stage_i,     // Decoded request
    input  ialu_data_pkg::ialu_word_t  addr_op1_i,  // Address adder operands
    input  ialu_data_pkg::ialu_word_t  addr_op2_i,
    output ialu_data_pkg::ialu_exec_s  exec_o,      // All unit results
    output ialu_data_pkg::ialu_word_t  addr_res_o   // Address sum, same cycle
);

    import ialu_cmd_pkg::*;
    import ialu_data_pkg::*;

    localparam int unsigned msb = `IALU_XLEN - 1;

    logic [`IALU_XLEN:0]           sum_ext;         // Sum with carry out
    logic                          op2_sgn_eff;     // Op2 sign as seen by the adder
    ialu_flags_s                   sum_flags;
    logic signed [`IALU_XLEN-1:0]  shift_src;
    logic [`IALU_SHAMT_W-1:0]      shamt;
    ialu_word_t                    shift_res;
    ialu_word_t                    logic_res;

    //--------------------------------------------------
    // Main adder
    //--------------------------------------------------
    // Zero-extended to 33 bits so bit 32 is the carry, or the borrow on subtract
    always_comb begin
        if (stage_i.dec.sub) begin
            sum_ext = {1'b0, stage_i.op1} - {1'b0, stage_i.op2};
        end else begin
            sum_ext = {1'b0, stage_i.op1} + {1'b0, stage_i.op2};
        end
    end

    // Subtract flips the effective sign of op2
    assign op2_sgn_eff = stage_i.op2[msb] ^ stage_i.dec.sub;

    always_comb begin
        sum_flags.carry = sum_ext[`IALU_XLEN];
        sum_flags.zero  = ~|sum_ext[msb:0];
        sum_flags.sign  = sum_ext[msb];
        // Same-sign operands giving a result of the other sign
        sum_flags.ovfl  = (stage_i.op1[msb] == op2_sgn_eff)
                        & (sum_ext[msb] != stage_i.op1[msb]);
    end

    //--------------------------------------------------
    // Shifter
    //--------------------------------------------------
    assign shift_src = stage_i.op1;
    assign shamt     = stage_i.op2[`IALU_SHAMT_W-1:0];     // Upper op2 bits ignored

    always_comb begin
        case (stage_i.dec.shift_op)
            ialu_shift_srl: shift_res = stage_i.op1 >> shamt;
            ialu_shift_sra: shift_res = shift_src >>> shamt;  // Bit 31 fills in
            default:        shift_res = stage_i.op1 << shamt;
        endcase
    end

    //--------------------------------------------------
    // Logic unit
    //--------------------------------------------------
    always_comb begin
        case (stage_i.dec.logic_op)
            ialu_logic_or:  logic_res = stage_i.op1 | stage_i.op2;
            ialu_logic_xor: logic_res = stage_i.op1 ^ stage_i.op2;
            default:        logic_res = stage_i.op1 & stage_i.op2;
        endcase
    end

    // Result stage picks by class
    assign exec_o = '{
        valid:     stage_i.valid,
        op_class:  stage_i.dec.op_class,
        cmp_op:    stage_i.dec.cmp_op,
        sum:       sum_ext[msb:0],          // Wraps at word width
        flags:     sum_flags,
        shift_res: shift_res,
        logic_res: logic_res
    };

    // Address adder, unregistered and independent of the main path
    assign addr_res_o = addr_op1_i + addr_op2_i;

endmodule

// ==== logic/ialu_result.sv ====
/* Output stage of the ALU. Resolves compares from the adder flags, selects
   the result by class and registers the response with its rdy pulse. */

`timescale 1ns/100ps

module ialu_result (
    input  logic                      clk,
    input  logic                      rst_n,
    input  ialu_data_pkg::ialu_exec_s exec_i,     // Unit results from execute
    output ialu_data_pkg::ialu_rsp_s  rsp_o       // Registered response
);

    import ialu_cmd_pkg::*;
    import ialu_data_pkg::*;

    logic       lt_s;           // Signed less-than
    logic       cmp_bit;        // Selected compare outcome
    ialu_word_t res_d;
    logic       cmp_d;
    logic       rdy_d;

    //--------------------------------------------------
    // Compare resolution
    //--------------------------------------------------
    assign lt_s = exec_i.flags.sign ^ exec_i.flags.ovfl;

    always_comb begin
        case (exec_i.cmp_op)
            ialu_cmp_lt:  cmp_bit = lt_s;
            ialu_cmp_ge:  cmp_bit = ~lt_s;
            ialu_cmp_ltu: cmp_bit = exec_i.flags.carry;     // Borrow out
            ialu_cmp_geu: cmp_bit = ~exec_i.flags.carry;
            ialu_cmp_eq:  cmp_bit = exec_i.flags.zero;
            ialu_cmp_ne:  cmp_bit = ~exec_i.flags.zero;
            default:      cmp_bit = 1'b0;
        endcase
    end

    //--------------------------------------------------
    // Result select
    //--------------------------------------------------
    always_comb begin
        res_d = '0;
        cmp_d = 1'b0;                   // Only compares raise cmp
        case (exec_i.op_class)
            ialu_class_logic: res_d = exec_i.logic_res;
            ialu_class_sum:   res_d = exec_i.sum;
            ialu_class_cmp: begin
                res_d = ialu_word_t'(cmp_bit);  // Zero-extended
                cmp_d = cmp_bit;
            end
            ialu_class_shift: res_d = exec_i.shift_res;
            default: begin
                res_d = '0;
                cmp_d = 1'b0;
            end
        endcase
    end

    // NONE decodes to class none, so it never pulses rdy
    assign rdy_d = exec_i.valid & (exec_i.op_class != ialu_class_none);

    //--------------------------------------------------
    // Output register
    //--------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_o.rdy <= 1'b0;
            rsp_o.cmp <= 1'b0;
            rsp_o.res <= '0;
        end else begin
            rsp_o.rdy <= rdy_d;
            rsp_o.cmp <= cmp_d;         // Loaded every cycle
            rsp_o.res <= res_d;
        end
    end

endmodule

// ==== logic/ialu_top.sv ====
/* Top level of the integer ALU. Chains decode, execute and result for a fixed
   two-cycle latency and brings out the combinational address adder. */

`timescale 1ns/100ps

module ialu_top (
    input  logic                      clk,
    input  logic                      rst_n,

    // Main path
    input  ialu_data_pkg::ialu_req_s  req_i,        // Strobe, cmd and operands
    output ialu_data_pkg::ialu_rsp_s  rsp_o,        // Result two edges later

    // Address path
    input  ialu_data_pkg::ialu_word_t addr_op1_i,
    input  ialu_data_pkg::ialu_word_t addr_op2_i,
    output ialu_data_pkg::ialu_word_t addr_res_o    // Same-cycle sum
);

    import ialu_data_pkg::*;

    ialu_stage_s stage;         // Decode register to execute
    ialu_exec_s  exec;          // Execute to output register

    //--------------------------------------------------
    // Pipeline
    //--------------------------------------------------
    ialu_decode i_decode (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_i   (req_i),
        .stage_o (stage)
    );

    // Combinational, sits between the two registers
    ialu_execute i_execute (
        .stage_i    (stage),
        .addr_op1_i (addr_op1_i),
        .addr_op2_i (addr_op2_i),
        .exec_o     (exec),
        .addr_res_o (addr_res_o)
    );

    ialu_result i_result (
        .clk    (clk),
        .rst_n  (rst_n),
        .exec_i (exec),
        .rsp_o  (rsp_o)
    );

endmodule

// ==== verif/ialu_vectors.svh ====
/* Stimulus and expected responses for the ALU testbench, one request per row.
   Included inside the testbench module after the vec_s type. */

// Columns: valid, cmd, op1, op2, expected res, expected cmp
// Rows with valid low or cmd NONE expect no rdy pulse
localparam int n_vectors = 36;

localparam vec_s vectors [n_vectors] = '{
    // Logic unit
    '{1'b1, ialu_cmd_and,     32'hF0F0_1234, 32'h0FF0_FF00, 32'h00F0_1200, 1'b0},
    '{1'b1, ialu_cmd_or,      32'hF0F0_1234, 32'h0FF0_FF00, 32'hFFF0_FF34, 1'b0},
    '{1'b1, ialu_cmd_xor,     32'hF0F0_1234, 32'h0FF0_FF00, 32'hFF00_ED34, 1'b0},
    // Add and subtract, wrapping
    '{1'b1, ialu_cmd_add,     32'h0000_0005, 32'h0000_0003, 32'h0000_0008, 1'b0},
    '{1'b1, ialu_cmd_add,     32'h7FFF_FFFF, 32'h0000_0001, 32'h8000_0000, 1'b0},
    '{1'b1, ialu_cmd_add,     32'hFFFF_FFFF, 32'h0000_0002, 32'h0000_0001, 1'b0},
    '{1'b1, ialu_cmd_sub,     32'h8000_0000, 32'h0000_0001, 32'h7FFF_FFFF, 1'b0},
    '{1'b1, ialu_cmd_sub,     32'h0000_0003, 32'h0000_0005, 32'hFFFF_FFFE, 1'b0},
    // Compares, -1 against 1 differs by sign view
    '{1'b1, ialu_cmd_sub_lt,  32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0001, 1'b1},
    '{1'b1, ialu_cmd_sub_ltu, 32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0000, 1'b0},
    '{1'b1, ialu_cmd_sub_ge,  32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0000, 1'b0},
    '{1'b1, ialu_cmd_sub_geu, 32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0001, 1'b1},
    '{1'b1, ialu_cmd_sub_lt,  32'h0000_0001, 32'hFFFF_FFFF, 32'h0000_0000, 1'b0},
    '{1'b1, ialu_cmd_sub_ltu, 32'h0000_0001, 32'hFFFF_FFFF, 32'h0000_0001, 1'b1},
    '{1'b1, ialu_cmd_sub_eq,  32'h1234_5678, 32'h1234_5678, 32'h0000_0001, 1'b1},
    '{1'b1, ialu_cmd_sub_ne,  32'h1234_5678, 32'h1234_5678, 32'h0000_0000, 1'b0},
    '{1'b1, ialu_cmd_sub_eq,  32'h1234_5678, 32'h1234_5679, 32'h0000_0000, 1'b0},
    '{1'b1, ialu_cmd_sub_ne,  32'h1234_5678, 32'h1234_5679, 32'h0000_0001, 1'b1},
    '{1'b1, ialu_cmd_sub_ge,  32'h8000_0000, 32'h7FFF_FFFF, 32'h0000_0000, 1'b0},
    '{1'b1, ialu_cmd_sub_lt,  32'h8000_0000, 32'h7FFF_FFFF, 32'h0000_0001, 1'b1},
    '{1'b1, ialu_cmd_sub_geu, 32'h0000_0005, 32'h0000_0005, 32'h0000_0001, 1'b1},
    '{1'b1, ialu_cmd_sub_lt,  32'h0000_0005, 32'h0000_0005, 32'h0000_0000, 1'b0},
    // Shifts, amount 33 acts as 1 and 32 as 0
    '{1'b1, ialu_cmd_sll,     32'h0000_0001, 32'h0000_0021, 32'h0000_0002, 1'b0},
    '{1'b1, ialu_cmd_sll,     32'h8000_0001, 32'h0000_0004, 32'h0000_0010, 1'b0},
    '{1'b1, ialu_cmd_srl,     32'h8000_0000, 32'h0000_0021, 32'h4000_0000, 1'b0},
    '{1'b1, ialu_cmd_sra,     32'h8000_0000, 32'h0000_0021, 32'hC000_0000, 1'b0},
    '{1'b1, ialu_cmd_sra,     32'hF000_0000, 32'h0000_0004, 32'hFF00_0000, 1'b0},
    '{1'b1, ialu_cmd_sra,     32'h7000_0000, 32'h0000_0004, 32'h0700_0000, 1'b0},
    '{1'b1, ialu_cmd_srl,     32'hF000_0000, 32'h0000_001F, 32'h0000_0001, 1'b0},
    '{1'b1, ialu_cmd_sll,     32'h1234_5678, 32'h0000_0020, 32'h1234_5678, 1'b0},
    // Gaps from NONE and valid low, order must hold across them
    '{1'b1, ialu_cmd_none,    32'h0000_0001, 32'h0000_0001, 32'h0000_0000, 1'b0},
    '{1'b0, ialu_cmd_add,     32'h0000_0001, 32'h0000_0001, 32'h0000_0000, 1'b0},
    '{1'b1, ialu_cmd_add,     32'h0000_0001, 32'h0000_0001, 32'h0000_0002, 1'b0},
    '{1'b0, ialu_cmd_sub_lt,  32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0000, 1'b0},
    '{1'b1, ialu_cmd_xor,     32'hFFFF_FFFF, 32'h0000_FFFF, 32'hFFFF_0000, 1'b0},
    '{1'b0, ialu_cmd_none,    32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 1'b0}
};

// ==== verif/ialu_tb.sv ====
/* Testbench for the integer ALU. Runs the vector table back to back, checks
   each response and its latency, and checks the address adder on random operands. */

`timescale 1ns/100ps

module ialu_tb;

    import ialu_cmd_pkg::*;
    import ialu_data_pkg::*;

    // One table row
    typedef struct packed {
        logic       valid;
        ialu_cmd_e  cmd;
        ialu_word_t op1;
        ialu_word_t op2;
        ialu_word_t res;
        logic       cmp;
    } vec_s;

    // Pending response with the cycle it is due in
    typedef struct {
        ialu_rsp_s rsp;
        int        due;
        int        idx;
    } exp_s;

    `include "ialu_vectors.svh"

    localparam int clk_period = 40;
    localparam int n_random   = 24;     // Address-only cycles after the table
    localparam int timeout_ns = (n_vectors + n_random + 20) * clk_period;

    logic       clk = 1'b0;
    logic       rst_n;
    ialu_req_s  req_i;
    ialu_rsp_s  rsp_o;
    ialu_word_t addr_op1_i;
    ialu_word_t addr_op2_i;
    ialu_word_t addr_res_o;

    integer     seed = 32'hdc5d_c911;
    int         cycle_cnt = 0;          // Rising edges seen so far
    int         value_errs = 0;
    int         proto_errs = 0;
    ialu_word_t addr_exp;
    exp_s       exp_q[$];

    ialu_top i_ialu_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_i      (req_i),
        .rsp_o      (rsp_o),
        .addr_op1_i (addr_op1_i),
        .addr_op2_i (addr_op2_i),
        .addr_res_o (addr_res_o)
    );

    always #(clk_period / 2) clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    //--------------------------------------------------
    // Compare tasks
    //--------------------------------------------------
    task automatic check_rsp(input string tag, input ialu_rsp_s exp, input ialu_rsp_s act);
        if (act.rdy !== exp.rdy) begin
            value_errs++;
            $display("ERROR %s rsp_o.rdy expected %h got %h", tag, exp.rdy, act.rdy);
        end
        if (act.cmp !== exp.cmp) begin
            value_errs++;
            $display("ERROR %s rsp_o.cmp expected %h got %h", tag, exp.cmp, act.cmp);
        end
        if (act.res !== exp.res) begin
            value_errs++;
            $display("ERROR %s rsp_o.res expected %h got %h", tag, exp.res, act.res);
        end
    endtask

    task automatic check_word(input string name, input ialu_word_t exp, input ialu_word_t act);
        if (act !== exp) begin
            value_errs++;
            $display("ERROR %s expected %h got %h", name, exp, act);
        end
    endtask

    // New address operands and their sum wrapped at 32 bits
    task automatic drive_addr();
        addr_op1_i = $random(seed);
        addr_op2_i = $random(seed);
        addr_exp   = addr_op1_i + addr_op2_i;
    endtask

    //--------------------------------------------------
    // Response monitor on the falling edge
    //--------------------------------------------------
    always @(negedge clk) begin : monitor
        exp_s e;
        if (rst_n) begin
            if (rsp_o.rdy) begin
                if (exp_q.size() == 0) begin
                    proto_errs++;
                    $display("Protocol error: rdy at cycle %0d with no request pending",
                             cycle_cnt);
                end else begin
                    e = exp_q.pop_front();
                    if (e.due != cycle_cnt) begin
                        proto_errs++;
                        $display("Protocol error: vector %0d answered at cycle %0d, due %0d",
                                 e.idx, cycle_cnt, e.due);
                    end
                    check_rsp($sformatf("vector %0d", e.idx), e.rsp, rsp_o);
                end
            end else if (exp_q.size() != 0 && exp_q[0].due <= cycle_cnt) begin
                e = exp_q.pop_front();   // Missed pulse is dropped
                proto_errs++;
                $display("Protocol error: vector %0d never got its rdy pulse", e.idx);
            end
        end
    end

    //--------------------------------------------------
    // Main sequence
    //--------------------------------------------------
    initial begin
        rst_n      = 1'b0;
        req_i      = '0;
        addr_op1_i = '0;
        addr_op2_i = '0;

        @(negedge clk);
        check_rsp("reset", '0, rsp_o);      // Inside reset
        @(posedge clk);                     // Second rising edge under reset
        #2 rst_n = 1'b1;
        @(negedge clk);
        check_rsp("after reset", '0, rsp_o);

        // One row per cycle with no idle cycles between
        for (int i = 0; i < n_vectors; i++) begin
            @(posedge clk);
            #2;
            req_i.valid = vectors[i].valid;
            req_i.cmd   = vectors[i].cmd;
            req_i.op1   = vectors[i].op1;
            req_i.op2   = vectors[i].op2;
            drive_addr();
            if (vectors[i].valid && vectors[i].cmd != ialu_cmd_none) begin
                exp_q.push_back('{rsp: '{rdy: 1'b1, cmp: vectors[i].cmp, res: vectors[i].res},
                                  due: cycle_cnt + 2, idx: i});
            end
            @(negedge clk);
            check_word("addr_res_o", addr_exp, addr_res_o);
        end

        // Address adder alone while the main path idles
        for (int i = 0; i < n_random; i++) begin
            @(posedge clk);
            #2;
            req_i = '0;
            drive_addr();
            @(negedge clk);
            check_word("addr_res_o", addr_exp, addr_res_o);
        end

        while (exp_q.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);          // Catch any stray rdy

        $display("Done: %0d value errors, %0d protocol errors", value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(timeout_ns);
        $display("Timeout: run still going after %0d ns", timeout_ns);
        $display("Some tests failed");
        $finish;
    end

endmodule
